// ==== all.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_cfg_regs.sv
logic/lsu_addr_gen.sv
logic/lsu_load_queue.sv
logic/lsu_load_format.sv
logic/lsu_commit_arb.sv
logic/lsu_top.sv
verification/lsu_mem_model.sv
verification/lsu_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f all.f -o lsu_sim
result=$(./obj_dir/lsu_sim)
echo "$result"

if echo "$result" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== verification/lsu_tb.sv ====
// testbench for the load/store unit
// random warp instructions, byte memory reference model,
// request and commit checks, back-pressure on the commit port

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int NUM_TXNS   = 400;
    localparam int WAIT_LIMIT = 3000;

    logic       clk;
    logic       reset;
    logic       cfg_wr_en;
    word_t      cfg_wr_data;
    logic       issue_valid;
    logic       issue_ready;
    lsu_issue_t issue;
    logic       mem_req_valid;
    logic       mem_req_ready;
    mem_req_t   mem_req;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    mem_rsp_t   mem_rsp;
    logic       commit_valid;
    logic       commit_ready;
    commit_t    commit;

    logic [7:0] model_mem [logic [31:0]];
    commit_t    exp_loads [$];
    commit_t    exp_stores [$];
    word_t      io_base_model = `LSU_IO_BASE_RESET;
    int         loads_issued = 0;
    int         rsp_accepted = 0;
    int         checks = 0;
    int         errors = 0;
    logic       timed_out = 1'b0;
    logic       draining = 1'b0;
    int         seed = 12977;
    int         ready_seed = 12977;

    lsu_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr_en     (cfg_wr_en),
        .cfg_wr_data   (cfg_wr_data),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue         (issue),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    lsu_mem_model mem0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp_ready (mem_rsp_ready),
        .rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [7:0] read_byte(input logic [31:0] addr);
        logic [7:0] b;
        if (model_mem.exists(addr)) begin
            b = model_mem[addr];
        end else begin
            b = addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5A;
        end
        return b;
    endfunction

    function automatic word_t load_value(input lsu_op_t op, input word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       v;
        b = read_byte(addr);
        h = {read_byte(addr + 1), b};
        case (op)
            `LSU_OP_LB:  v = {{24{b[7]}}, b};
            `LSU_OP_LH:  v = {{16{h[15]}}, h};
            `LSU_OP_LBU: v = {24'h0, b};
            `LSU_OP_LHU: v = {16'h0, h};
            default:     v = {read_byte(addr + 3), read_byte(addr + 2), h};
        endcase
        return v;
    endfunction

    function automatic byteen_t store_byteen(input lsu_op_t op, input align_t align);
        byteen_t be;
        case (op)
            `LSU_OP_SB: be = 4'b0001 << align;
            `LSU_OP_SH: be = 4'b0011 << align;
            default:    be = 4'b1111;
        endcase
        return be;
    endfunction

    task automatic make_issue(output lsu_issue_t t);
        int    r;
        int    lane_r;
        word_t region;
        word_t amask;
        word_t sum;
        r = $random(seed);
        case (r[7:0] % 10)
            0:       t.op = `LSU_OP_LB;
            1:       t.op = `LSU_OP_LH;
            2:       t.op = `LSU_OP_LW;
            3:       t.op = `LSU_OP_LBU;
            4:       t.op = `LSU_OP_LHU;
            5:       t.op = `LSU_OP_SB;
            6:       t.op = `LSU_OP_SH;
            7:       t.op = `LSU_OP_SW;
            8:       t.op = `LSU_OP_LW;
            default: t.op = `LSU_OP_FENCE;
        endcase
        case (t.op)
            `LSU_OP_LH, `LSU_OP_LHU, `LSU_OP_SH: amask = 32'h1;
            `LSU_OP_LW, `LSU_OP_SW:              amask = 32'h3;
            default:                             amask = 32'h0;
        endcase
        t.wid   = r[9:8];
        t.rd    = r[14:10];
        t.tmask = r[18:15];
        t.imm   = {{27{r[25]}}, r[25:21]};
        // high window straddles the reset I/O base
        region  = (r[20:19] == 2'b00) ? 32'hFEFF_FF80 : 32'h0000_1000;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            lane_r       = $random(seed);
            t.base[i]    = region + (lane_r & 32'h1FF);
            sum          = t.base[i] + t.imm;
            t.base[i]    = t.base[i] - (sum & amask);
            t.st_data[i] = $random(seed);
        end
    endtask

    task automatic check_request(input lsu_issue_t t, input logic is_st);
        word_t addr;
        word_t shifted;
        compare(mem_req_valid && mem_req_ready, 1'b1, "memory request with the issue");
        compare(mem_req.rw, is_st, "request rw");
        compare(mem_req.mask, t.tmask, "request mask");
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            addr    = t.base[i] + t.imm;
            shifted = t.st_data[i] << (8 * addr[1:0]);
            if (t.tmask[i]) begin
                compare(mem_req.addr[i], addr[31:2], $sformatf("lane %0d word address", i));
                compare(mem_req.io[i], addr >= io_base_model, $sformatf("lane %0d io flag", i));
                if (is_st) begin
                    compare(mem_req.byteen[i], store_byteen(t.op, addr[1:0]),
                            $sformatf("lane %0d byte enables", i));
                    compare(mem_req.data[i], shifted, $sformatf("lane %0d store data", i));
                    for (int k = 0; k < 4; k++) begin
                        if (store_byteen(t.op, addr[1:0]) & (4'b0001 << k)) begin
                            model_mem[{addr[31:2], 2'(k)}] = shifted[8*k +: 8];
                        end
                    end
                end
            end
        end
    endtask

    task automatic record_issue(input lsu_issue_t t);
        commit_t rec;
        rec.wid   = t.wid;
        rec.tmask = t.tmask;
        rec.rd    = '0;
        rec.wb    = 1'b0;
        rec.data  = '0;
        if (t.op == `LSU_OP_FENCE) begin
            compare(rsp_accepted, loads_issued, "load responses before the fence");
            exp_stores.push_back(rec);
        end else if (t.op inside {`LSU_OP_SB, `LSU_OP_SH, `LSU_OP_SW}) begin
            check_request(t, 1'b1);
            exp_stores.push_back(rec);
        end else begin
            check_request(t, 1'b0);
            rec.rd = t.rd;
            rec.wb = 1'b1;
            for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                if (t.tmask[i]) begin
                    rec.data[i] = load_value(t.op, t.base[i] + t.imm);
                end
            end
            exp_loads.push_back(rec);
            loads_issued++;
        end
    endtask

    task automatic check_commit();
        commit_t exp;
        if ((commit.wb && exp_loads.size() == 0) || (!commit.wb && exp_stores.size() == 0)) begin
            errors++;
            $display("commit at %0t has no matching instruction in the model", $time);
        end else begin
            if (commit.wb) begin
                exp = exp_loads.pop_front();
            end else begin
                exp = exp_stores.pop_front();
            end
            compare(commit.wid, exp.wid, "commit wid");
            compare(commit.tmask, exp.tmask, "commit tmask");
            compare(commit.rd, exp.rd, "commit rd");
            for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                if (exp.tmask[i] || !exp.wb) begin
                    compare(commit.data[i], exp.data[i], $sformatf("commit lane %0d data", i));
                end
            end
        end
    endtask

    // monitor, runs on pre-edge values
    always @(posedge clk) begin
        if (!reset) begin
            if (issue_valid && issue.op == `LSU_OP_FENCE) begin
                compare(mem_req_valid, 1'b0, "fence memory request");
            end
            if (issue_valid && issue_ready) begin
                record_issue(issue);
            end else if (mem_req_valid && mem_req_ready) begin
                errors++;
                $display("memory request at %0t without an accepted issue", $time);
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_accepted++;
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (cfg_wr_en) begin
                io_base_model = cfg_wr_data;
            end
        end
    end

    // ready is sampled mid-cycle, the transfer happens on the next edge
    task automatic send_issue(input lsu_issue_t t);
        int waited;
        waited = 0;
        issue_valid <= 1'b1;
        issue       <= t;
        @(negedge clk);
        while (!issue_ready && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: opcode %0h was not accepted in %0d cycles", t.op, WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    // long low stretches on the commit port
    initial begin
        int   r;
        int   stretch;
        logic level;
        commit_ready <= 1'b0;
        forever begin
            r       = $random(ready_seed);
            level   = r[0];
            stretch = level ? 1 + r[4:1] : 1 + r[10:5];
            for (int k = 0; k < stretch; k++) begin
                @(posedge clk);
                commit_ready <= level || draining;
            end
        end
    end

    initial begin
        lsu_issue_t t;
        int         r;
        int         waited;
        reset       <= 1'b1;
        cfg_wr_en   <= 1'b0;
        cfg_wr_data <= '0;
        issue_valid <= 1'b0;
        issue       <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_TXNS && !timed_out; n++) begin
            r = $random(seed);
            if (n == 150 || n == 280) begin
                cfg_wr_en   <= 1'b1;
                cfg_wr_data <= 32'h0000_1000 + (r & 32'h1FF);
                @(posedge clk);
                cfg_wr_en <= 1'b0;
            end else if (r[11:10] == 2'b00) begin
                @(posedge clk);
            end
            make_issue(t);
            send_issue(t);
        end
        draining = 1'b1;
        waited   = 0;
        while (!timed_out && (exp_loads.size() + exp_stores.size() > 0)) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d commits never arrived",
                         exp_loads.size() + exp_stores.size());
                timed_out = 1'b1;
            end
        end
        // quiet period to catch duplicated commits
        repeat (20) @(posedge clk);
        compare(rsp_accepted, loads_issued, "load responses against loads issued");
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/lsu_mem_model.sv ====
// memory responder for the load/store unit testbench
// word memory with an address-based fill, random request ready,
// in-order load responses after a random delay

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_mem_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::mem_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::mem_rsp_t rsp
);
    import lsu_pkg::*;

    word_t    mem [logic [29:0]];
    mem_rsp_t rsp_q [$];
    int       due_q [$];
    int       cycle = 0;
    int       seed = 12977;
    int       r;
    mem_rsp_t rd_rsp;
    word_t    w;

    // unwritten words hold a pattern of their byte addresses
    function automatic word_t read_word(input logic [29:0] waddr);
        word_t       v;
        logic [31:0] a;
        if (mem.exists(waddr)) begin
            v = mem[waddr];
        end else begin
            for (int k = 0; k < 4; k++) begin
                a = {waddr, 2'(k)};
                v[8*k +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
            end
        end
        return v;
    endfunction

    initial begin
        req_ready <= 1'b0;
        rsp_valid <= 1'b0;
        rsp       <= '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_q.delete();
            due_q.delete();
        end else begin
            cycle = cycle + 1;
            r = $random(seed);
            if (req_valid && req_ready) begin
                for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                    w = read_word(req.addr[i]);
                    if (req.rw && req.mask[i]) begin
                        for (int k = 0; k < 4; k++) begin
                            if (req.byteen[i][k]) begin
                                w[8*k +: 8] = req.data[i][8*k +: 8];
                            end
                        end
                        mem[req.addr[i]] = w;
                    end
                    rd_rsp.data[i] = req.mask[i] ? w : '0;
                end
                if (!req.rw) begin
                    rsp_q.push_back(rd_rsp);
                    due_q.push_back(cycle + r[1:0]);
                end
            end
            if (rsp_valid && rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            // hold the current response until it is taken
            if (!rsp_valid || rsp_ready) begin
                if (rsp_q.size() > 0 && due_q[0] <= cycle) begin
                    rsp_valid <= 1'b1;
                    rsp       <= rsp_q[0];
                end else begin
                    rsp_valid <= 1'b0;
                end
            end
            req_ready <= (r[3:2] != 2'b00);
        end
    end

endmodule

// ==== logic/lsu_top.sv ====
// load/store unit top level
// opcode decode, issue and memory handshakes, fence stall,
// load metadata and commit record assembly

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_wr_en,
    input  lsu_pkg::word_t      cfg_wr_data,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  lsu_pkg::lsu_issue_t issue,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output lsu_pkg::mem_req_t   mem_req,
    input  logic                mem_rsp_valid,
    output logic                mem_rsp_ready,
    input  lsu_pkg::mem_rsp_t   mem_rsp,
    output logic                commit_valid,
    input  logic                commit_ready,
    output lsu_pkg::commit_t    commit
);
    import lsu_pkg::*;

    word_t                      io_base;
    logic                       issue_en;
    logic                       is_load;
    logic                       is_store;
    logic                       is_fence;
    logic                       lq_push;
    logic                       lq_pop;
    logic                       lq_full;
    logic                       lq_empty;
    logic                       st_valid;
    logic                       st_ready;
    load_meta_t                 push_meta;
    load_meta_t                 pop_meta;
    word_t [`LSU_NUM_LANES-1:0] load_data;
    commit_t                    ld_commit;
    commit_t                    st_commit;

    // hold off issue until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_en <= 1'b0;
        end else begin
            issue_en <= 1'b1;
        end
    end

    assign is_store = issue.op inside {`LSU_OP_SB, `LSU_OP_SH, `LSU_OP_SW};
    assign is_fence = (issue.op == `LSU_OP_FENCE);
    assign is_load  = ~is_store && ~is_fence;

    // fence waits for every outstanding load response
    assign issue_ready = issue_en && (is_fence ? (lq_empty && st_ready)
                       : (mem_req_ready && (is_load ? ~lq_full : st_ready)));

    assign mem_req_valid = issue_valid && issue_en
                         && ((is_load && ~lq_full) || (is_store && st_ready));

    // fence retires through the store path as a wb 0 record
    assign st_valid = issue_valid && issue_en
                    && ((is_store && mem_req_ready) || (is_fence && lq_empty));

    assign lq_push = mem_req_valid && mem_req_ready && is_load;
    assign lq_pop  = mem_rsp_valid && mem_rsp_ready;

    always_comb begin
        push_meta.wid   = issue.wid;
        push_meta.rd    = issue.rd;
        push_meta.tmask = issue.tmask;
        push_meta.op    = issue.op;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            push_meta.align[i] = issue.base[i][1:0] + issue.imm[1:0];
        end
    end

    always_comb begin
        ld_commit.wid   = pop_meta.wid;
        ld_commit.tmask = pop_meta.tmask;
        ld_commit.rd    = pop_meta.rd;
        ld_commit.wb    = 1'b1;
        ld_commit.data  = load_data;

        st_commit.wid   = issue.wid;
        st_commit.tmask = issue.tmask;
        st_commit.rd    = '0;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
    end

    lsu_cfg_regs cfg_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_data (cfg_wr_data),
        .io_base     (io_base)
    );

    lsu_addr_gen addr_gen (
        .issue   (issue),
        .io_base (io_base),
        .mem_req (mem_req)
    );

    lsu_load_queue load_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (lq_push),
        .push_meta (push_meta),
        .pop       (lq_pop),
        .pop_meta  (pop_meta),
        .full      (lq_full),
        .empty     (lq_empty)
    );

    lsu_load_format load_format (
        .meta      (pop_meta),
        .mem_rsp   (mem_rsp),
        .load_data (load_data)
    );

    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (mem_rsp_valid),
        .ld_commit    (ld_commit),
        .ld_ready     (mem_rsp_ready),
        .st_valid     (st_valid),
        .st_commit    (st_commit),
        .st_ready     (st_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// ==== logic/lsu_commit_arb.sv ====
// commit path
// 2-entry load and store buffers, round-robin arbiter, registered output

`timescale 1ns/1ns

module lsu_commit_arb (
    input  logic             clk,
    input  logic             reset,
    input  logic             ld_valid,
    input  lsu_pkg::commit_t ld_commit,
    output logic             ld_ready,
    input  logic             st_valid,
    input  lsu_pkg::commit_t st_commit,
    output logic             st_ready,
    output logic             commit_valid,
    output lsu_pkg::commit_t commit,
    input  logic             commit_ready
);
    import lsu_pkg::*;

    // channel 0 is loads, channel 1 is stores
    logic [1:0]    in_valid;
    commit_t [1:0] in_data;
    logic [1:0]    buf_ready;
    logic [1:0]    buf_valid;
    commit_t [1:0] buf_data;
    logic [1:0]    buf_pop;
    logic [1:0]    grant;
    logic          last_grant;
    logic          out_ready;

    assign in_valid = {st_valid, ld_valid};
    assign in_data  = {st_commit, ld_commit};
    assign ld_ready = buf_ready[0];
    assign st_ready = buf_ready[1];

    for (genvar c = 0; c < 2; c++) begin : g_buf
        commit_t    entry [2];
        logic       wr_ptr;
        logic       rd_ptr;
        logic       push;
        logic [1:0] count;

        assign push = in_valid[c] && buf_ready[c];

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= 1'b0;
                rd_ptr <= 1'b0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= ~wr_ptr;
                end
                if (buf_pop[c]) begin
                    rd_ptr <= ~rd_ptr;
                end
                count <= count + 2'(push) - 2'(buf_pop[c]);
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                entry[wr_ptr] <= in_data[c];
            end
        end

        assign buf_ready[c] = (count != 2'd2);
        assign buf_valid[c] = (count != 2'd0);
        assign buf_data[c]  = entry[rd_ptr];
    end

    // on conflict, the channel not served last wins
    always_comb begin
        if (buf_valid == 2'b11) begin
            grant = last_grant ? 2'b01 : 2'b10;
        end else begin
            grant = buf_valid;
        end
    end

    assign out_ready = ~commit_valid || commit_ready;
    assign buf_pop   = grant & {2{out_ready}};

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            last_grant   <= 1'b0;
        end else if (out_ready) begin
            commit_valid <= |grant;
            if (|grant) begin
                last_grant <= grant[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready && (|grant)) begin
            commit <= grant[1] ? buf_data[1] : buf_data[0];
        end
    end

endmodule

// ==== logic/lsu_load_format.sv ====
// load response formatting
// per-lane half/byte select by align, then sign or zero extension by opcode

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_load_format (
    input  lsu_pkg::load_meta_t                     meta,
    input  lsu_pkg::mem_rsp_t                       mem_rsp,
    output lsu_pkg::word_t [`LSU_NUM_LANES-1:0]     load_data
);

    logic [`LSU_NUM_LANES-1:0][15:0] lane_half;
    logic [`LSU_NUM_LANES-1:0][7:0]  lane_byte;

    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            lane_half[i] = meta.align[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
            lane_byte[i] = meta.align[i][0] ? lane_half[i][15:8] : lane_half[i][7:0];
            case (meta.op)
                `LSU_OP_LB: begin
                    load_data[i] = {{(`LSU_XLEN-8){lane_byte[i][7]}}, lane_byte[i]};
                end
                `LSU_OP_LH: begin
                    load_data[i] = {{(`LSU_XLEN-16){lane_half[i][15]}}, lane_half[i]};
                end
                `LSU_OP_LBU: begin
                    load_data[i] = {{(`LSU_XLEN-8){1'b0}}, lane_byte[i]};
                end
                `LSU_OP_LHU: begin
                    load_data[i] = {{(`LSU_XLEN-16){1'b0}}, lane_half[i]};
                end
                // word load passes through
                default: begin
                    load_data[i] = mem_rsp.data[i];
                end
            endcase
        end
    end

endmodule

// ==== logic/lsu_load_queue.sv ====
// in-order queue of outstanding load metadata
// circular buffer with read/write pointers, count, full and empty flags

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_load_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  lsu_pkg::load_meta_t push_meta,
    input  logic                pop,
    output lsu_pkg::load_meta_t pop_meta,
    output logic                full,
    output logic                empty
);
    import lsu_pkg::*;

    localparam int DEPTH    = `LSU_QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    load_meta_t          entries [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + PTR_BITS'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + PTR_BITS'(1);
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_meta;
        end
    end

    // oldest outstanding load
    assign pop_meta = entries[rd_ptr];
    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);

endmodule

// ==== logic/lsu_addr_gen.sv ====
// per-lane address generation and request formatting
// word address, I/O flag, byte enables, aligned store data and mask

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_addr_gen (
    input  lsu_pkg::lsu_issue_t issue,
    input  lsu_pkg::word_t      io_base,
    output lsu_pkg::mem_req_t   mem_req
);
    import lsu_pkg::*;

    word_t   [`LSU_NUM_LANES-1:0] full_addr;
    align_t  [`LSU_NUM_LANES-1:0] lane_align;
    byteen_t [`LSU_NUM_LANES-1:0] lane_byteen;
    word_t   [`LSU_NUM_LANES-1:0] lane_data;
    lane_mask_t                   lane_io;
    logic                         is_store;

    assign is_store = issue.op inside {`LSU_OP_SB, `LSU_OP_SH, `LSU_OP_SW};

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        assign full_addr[i]  = issue.base[i] + issue.imm;
        assign lane_align[i] = full_addr[i][1:0];
        // non-cacheable region starts at io_base
        assign lane_io[i]    = (full_addr[i] >= io_base);
        assign lane_data[i]  = issue.st_data[i] << {lane_align[i], 3'b000};
    end

    // loads read the whole word
    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            case (issue.op)
                `LSU_OP_SB: begin
                    lane_byteen[i] = byteen_t'(1) << lane_align[i];
                end
                `LSU_OP_SH: begin
                    lane_byteen[i] = byteen_t'(3) << {lane_align[i][1], 1'b0};
                end
                default: begin
                    lane_byteen[i] = '1;
                end
            endcase
        end
    end

    always_comb begin
        mem_req.rw     = is_store;
        mem_req.mask   = issue.tmask;
        mem_req.byteen = lane_byteen;
        mem_req.data   = lane_data;
        mem_req.io     = lane_io;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            mem_req.addr[i] = full_addr[i][`LSU_XLEN-1:2];
        end
    end

endmodule

// ==== logic/lsu_cfg_regs.sv ====
// configuration register block
// holds the I/O base address, loaded by a one-cycle write strobe

`timescale 1ns/1ns

`include "lsu_defs.svh"

module lsu_cfg_regs (
    input  logic           clk,
    input  logic           reset,
    input  logic           cfg_wr_en,
    input  lsu_pkg::word_t cfg_wr_data,
    output lsu_pkg::word_t io_base
);

    // new base applies to requests from the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            io_base <= `LSU_IO_BASE_RESET;
        end else if (cfg_wr_en) begin
            io_base <= cfg_wr_data;
        end
    end

endmodule

// ==== logic/lsu_pkg.sv ====
// shared types of the load/store unit
// vector typedefs plus issue, memory, load queue and commit records

`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]      word_t;
    typedef logic [`LSU_NUM_LANES-1:0] lane_mask_t;
    typedef logic [`LSU_XLEN/8-1:0]    byteen_t;
    typedef logic [1:0]                align_t;
    typedef logic [`LSU_WARP_BITS-1:0] wid_t;
    typedef logic [`LSU_RD_BITS-1:0]   rd_t;
    typedef logic [3:0]                lsu_op_t;

    typedef struct packed {
        lsu_op_t                    op;
        wid_t                       wid;
        rd_t                        rd;
        lane_mask_t                 tmask;
        word_t [`LSU_NUM_LANES-1:0] base;
        word_t                      imm;
        word_t [`LSU_NUM_LANES-1:0] st_data;
    } lsu_issue_t;

    // word addresses, low two bits dropped
    typedef struct packed {
        logic                                      rw;
        lane_mask_t                                mask;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-3:0]  addr;
        byteen_t [`LSU_NUM_LANES-1:0]              byteen;
        word_t [`LSU_NUM_LANES-1:0]                data;
        lane_mask_t                                io;
    } mem_req_t;

    typedef struct packed {
        word_t [`LSU_NUM_LANES-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        wid_t                        wid;
        rd_t                         rd;
        lane_mask_t                  tmask;
        lsu_op_t                     op;
        align_t [`LSU_NUM_LANES-1:0] align;
    } load_meta_t;

    typedef struct packed {
        wid_t                       wid;
        lane_mask_t                 tmask;
        rd_t                        rd;
        logic                       wb;
        word_t [`LSU_NUM_LANES-1:0] data;
    } commit_t;

endpackage

// ==== logic/lsu_defs.svh ====
// load/store unit configuration macros
// lane count, widths, queue depth, reset values and opcode codes

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

`define LSU_NUM_LANES     4
`define LSU_XLEN          32
`define LSU_WARP_BITS     2
`define LSU_RD_BITS       5
`define LSU_QUEUE_DEPTH   4

// top 16 MB of the address space
`define LSU_IO_BASE_RESET 32'hFF00_0000

`define LSU_OP_LB         4'h0
`define LSU_OP_LH         4'h1
`define LSU_OP_LW         4'h2
`define LSU_OP_LBU        4'h4
`define LSU_OP_LHU        4'h5
`define LSU_OP_SB         4'h8
`define LSU_OP_SH         4'h9
`define LSU_OP_SW         4'hA
`define LSU_OP_FENCE      4'hF

`endif
